/* Bender.yml */
package:
  name: oflow_iou_match

sources:
  - files:
      - rtl/oflow_iou_pkg.sv
      - rtl/oflow_seq_divider.sv
      - rtl/oflow_calc_iou.sv
      - rtl/oflow_history_bank.sv
      - rtl/oflow_best_match.sv
      - rtl/oflow_iou_match.sv
  - target: simulation
    files:
      - sim/oflow_iou_match_tb.sv

/* oflow_iou_match.f */
rtl/oflow_iou_pkg.sv
rtl/oflow_seq_divider.sv
rtl/oflow_calc_iou.sv
rtl/oflow_history_bank.sv
rtl/oflow_best_match.sv
rtl/oflow_iou_match.sv
sim/oflow_iou_match_tb.sv

/* rtl/oflow_best_match.sv */
/* det_start while busy is ignored; threshold is sampled in the report cycle
   lowest cost wins, lower slot on a tie; no valid slot gives idx 0 and cost all ones */
`timescale 1ns/10ps
`default_nettype none

module oflow_best_match #(
	parameter int HISTORY_DEPTH = 8
) (
	input wire clk,
	input wire reset_N,
	input wire det_start,
	input wire [oflow_iou_pkg::COST_LEN-1:0] cost_threshold,
	output logic [$clog2(HISTORY_DEPTH)-1:0] rd_idx,
	input wire rd_valid,
	output logic iou_start,
	input wire valid_iou,
	input wire [oflow_iou_pkg::COST_LEN-1:0] iou_cost,
	output logic busy,
	output logic match_done,
	output logic match_found,
	output logic [$clog2(HISTORY_DEPTH)-1:0] match_idx,
	output logic [oflow_iou_pkg::COST_LEN-1:0] match_cost
);

	localparam int IDX_LEN = $clog2(HISTORY_DEPTH);

	oflow_iou_pkg::match_state_t state;
	logic [IDX_LEN-1:0] slot;
	logic last_slot;

	// running best
	logic any_valid;
	logic [oflow_iou_pkg::COST_LEN-1:0] best_cost;
	logic [IDX_LEN-1:0] best_idx;
	logic take_new;

	assign rd_idx = slot;
	assign last_slot = (slot == IDX_LEN'(HISTORY_DEPTH - 1));
	assign busy = (state != oflow_iou_pkg::match_idle);
	// launch only on a valid slot
	assign iou_start = (state == oflow_iou_pkg::match_fetch) && rd_valid;
	// strict less-than keeps the lower slot on ties
	assign take_new = !any_valid || (iou_cost < best_cost);

	// --------------------------------------------------
	// scan FSM
	// --------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= oflow_iou_pkg::match_idle;
			slot <= '0;
			any_valid <= 1'b0;
			best_cost <= '1;
			best_idx <= '0;
			match_done <= 1'b0;
			match_found <= 1'b0;
			match_idx <= '0;
			match_cost <= '1;
		end else begin
			match_done <= 1'b0;
			case (state)
				oflow_iou_pkg::match_idle: begin
					if (det_start) begin
						state <= oflow_iou_pkg::match_fetch;
						slot <= '0;
						any_valid <= 1'b0;
						best_cost <= '1;
						best_idx <= '0;
					end
				end
				oflow_iou_pkg::match_fetch: begin
					if (rd_valid) begin
						state <= oflow_iou_pkg::match_wait_iou;
					end else if (last_slot) begin
						state <= oflow_iou_pkg::match_report;
					end else begin
						// empty slot, one cycle
						slot <= slot + 1'b1;
					end
				end
				oflow_iou_pkg::match_wait_iou: begin
					if (valid_iou) begin
						any_valid <= 1'b1;
						if (take_new) begin
							best_cost <= iou_cost;
							best_idx <= slot;
						end
						if (last_slot) begin
							state <= oflow_iou_pkg::match_report;
						end else begin
							state <= oflow_iou_pkg::match_fetch;
							slot <= slot + 1'b1;
						end
					end
				end
				default: begin
					// results held until the next report
					state <= oflow_iou_pkg::match_idle;
					match_done <= 1'b1;
					match_found <= any_valid && (best_cost <= cost_threshold);
					match_idx <= best_idx;
					match_cost <= best_cost;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/oflow_calc_iou.sv */
/* cost = 1 - IoU in COST_FRAC fraction bits, all ones for zero union
   widths are br - tl, so a box with tl == br has zero area; start while busy is dropped */
`timescale 1ns/10ps
`default_nettype none

module oflow_calc_iou (
	input wire clk,
	input wire reset_N,
	input wire start,
	input wire [oflow_iou_pkg::BBOX_LEN-1:0] bbox_frame_k,
	input wire [oflow_iou_pkg::BBOX_LEN-1:0] bbox_frame_history,
	output logic valid_iou,
	output logic [oflow_iou_pkg::COST_LEN-1:0] iou_cost
);

	localparam int CL = oflow_iou_pkg::COORD_LEN;
	localparam int BL = oflow_iou_pkg::BBOX_LEN;
	localparam int AL = oflow_iou_pkg::AREA_LEN;
	localparam int UL = oflow_iou_pkg::UNION_LEN;
	localparam int FRAC = oflow_iou_pkg::COST_FRAC;
	localparam int NL = oflow_iou_pkg::DIV_NUM_LEN;

	oflow_iou_pkg::calc_state_t state;

	// captured boxes
	logic [BL-1:0] box_k;
	logic [BL-1:0] box_h;

	// intersection corners
	logic [CL-1:0] ix_tl;
	logic [CL-1:0] iy_tl;
	logic [CL-1:0] ix_br;
	logic [CL-1:0] iy_br;

	logic [AL-1:0] area_k;
	logic [AL-1:0] area_h;
	logic [AL-1:0] inter;
	logic [UL-1:0] union_d;
	logic [AL-1:0] inter_q;
	logic [UL-1:0] union_q;

	logic div_start;
	logic div_done;
	logic div_by_zero;
	logic [NL-1:0] quotient;
	logic [oflow_iou_pkg::COST_LEN-1:0] cost_d;

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	function automatic logic [CL-1:0] fld(input logic [BL-1:0] box, input int msb);
		return box[msb -: CL];
	endfunction

	function automatic logic [CL-1:0] max_c(input logic [CL-1:0] a, input logic [CL-1:0] b);
		return (a > b) ? a : b;
	endfunction

	function automatic logic [CL-1:0] min_c(input logic [CL-1:0] a, input logic [CL-1:0] b);
		return (a < b) ? a : b;
	endfunction

	function automatic logic [AL-1:0] box_area(input logic [BL-1:0] box);
		logic [CL-1:0] w;
		logic [CL-1:0] h;
		w = fld(box, oflow_iou_pkg::X_BR_MSB) - fld(box, oflow_iou_pkg::X_TL_MSB);
		h = fld(box, oflow_iou_pkg::Y_BR_MSB) - fld(box, oflow_iou_pkg::Y_TL_MSB);
		return AL'(w) * AL'(h);
	endfunction

	// --------------------------------------------------
	// area stage and cost conversion
	// --------------------------------------------------
	always_comb begin
		area_k = box_area(box_k);
		area_h = box_area(box_h);
		// no overlap on either axis
		if ((ix_br < ix_tl) || (iy_br < iy_tl)) begin
			inter = '0;
		end else begin
			inter = AL'(ix_br - ix_tl) * AL'(iy_br - iy_tl);
		end
		// inter never exceeds either area
		union_d = UL'(area_k) + UL'(area_h) - UL'(inter);

		if (div_by_zero) begin
			cost_d = '1;
		end else if (|quotient[NL-1:FRAC]) begin
			// ratio reached one, full overlap
			cost_d = '0;
		end else begin
			// (2^FRAC - 1) - q
			cost_d = ~quotient[FRAC-1:0];
		end
	end

	// --------------------------------------------------
	// datapath registers
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if ((state == oflow_iou_pkg::calc_idle) && start) begin
			box_k <= bbox_frame_k;
			box_h <= bbox_frame_history;
		end
		if (state == oflow_iou_pkg::calc_coord) begin
			ix_tl <= max_c(fld(box_k, oflow_iou_pkg::X_TL_MSB), fld(box_h, oflow_iou_pkg::X_TL_MSB));
			iy_tl <= max_c(fld(box_k, oflow_iou_pkg::Y_TL_MSB), fld(box_h, oflow_iou_pkg::Y_TL_MSB));
			ix_br <= min_c(fld(box_k, oflow_iou_pkg::X_BR_MSB), fld(box_h, oflow_iou_pkg::X_BR_MSB));
			iy_br <= min_c(fld(box_k, oflow_iou_pkg::Y_BR_MSB), fld(box_h, oflow_iou_pkg::Y_BR_MSB));
		end
		if (state == oflow_iou_pkg::calc_area) begin
			inter_q <= inter;
			union_q <= union_d;
		end
		if ((state == oflow_iou_pkg::calc_divide) && div_done) begin
			iou_cost <= cost_d;
		end
	end

	// --------------------------------------------------
	// FSM
	// --------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= oflow_iou_pkg::calc_idle;
			div_start <= 1'b0;
			valid_iou <= 1'b0;
		end else begin
			div_start <= 1'b0;
			valid_iou <= 1'b0;
			case (state)
				oflow_iou_pkg::calc_idle: begin
					if (start) begin
						state <= oflow_iou_pkg::calc_coord;
					end
				end
				oflow_iou_pkg::calc_coord: begin
					state <= oflow_iou_pkg::calc_area;
				end
				oflow_iou_pkg::calc_area: begin
					// divider kicks off next cycle
					state <= oflow_iou_pkg::calc_divide;
					div_start <= 1'b1;
				end
				default: begin
					if (div_done) begin
						state <= oflow_iou_pkg::calc_idle;
						valid_iou <= 1'b1;
					end
				end
			endcase
		end
	end

	oflow_seq_divider #(
		.NUM_LEN(NL),
		.DEN_LEN(UL)
	) div0 (
		.clk(clk),
		.reset_N(reset_N),
		.start(div_start),
		.dividend({inter_q, {FRAC{1'b0}}}),
		.divisor(union_q),
		.done(div_done),
		.div_by_zero(div_by_zero),
		.quotient(quotient)
	);

endmodule

`default_nettype wire

/* rtl/oflow_history_bank.sv */
/* HISTORY_DEPTH >= 2; read is combinational, boxes are not cleared by reset
   clear and write in one cycle leave only the written slot valid */
`timescale 1ns/10ps
`default_nettype none

module oflow_history_bank #(
	parameter int HISTORY_DEPTH = 8
) (
	input wire clk,
	input wire reset_N,
	input wire wr,
	input wire [$clog2(HISTORY_DEPTH)-1:0] wr_idx,
	input wire [oflow_iou_pkg::BBOX_LEN-1:0] wr_box,
	input wire clear,
	input wire [$clog2(HISTORY_DEPTH)-1:0] rd_idx,
	output logic [oflow_iou_pkg::BBOX_LEN-1:0] rd_box,
	output logic rd_valid
);

	// box storage, one entry per slot
	logic [oflow_iou_pkg::BBOX_LEN-1:0] boxes [HISTORY_DEPTH];
	logic [HISTORY_DEPTH-1:0] valid;
	logic [HISTORY_DEPTH-1:0] valid_next;

	// --------------------------------------------------
	// storage
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (wr) begin
			boxes[wr_idx] <= wr_box;
		end
	end

	// clear first, the write then sets its own bit
	always_comb begin
		valid_next = clear ? '0 : valid;
		if (wr) begin
			valid_next[wr_idx] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			valid <= '0;
		end else begin
			valid <= valid_next;
		end
	end

	// --------------------------------------------------
	// read port
	// --------------------------------------------------
	// same cycle as rd_idx
	assign rd_box = boxes[rd_idx];
	assign rd_valid = valid[rd_idx];

endmodule

`default_nettype wire

/* rtl/oflow_iou_match.sv */
/* det_box and cost_threshold must stay stable while busy
   no history writes during a scan */
`timescale 1ns/10ps
`default_nettype none

module oflow_iou_match #(
	parameter int HISTORY_DEPTH = 8
) (
	input wire clk,
	input wire reset_N,
	input wire hist_wr,
	input wire [$clog2(HISTORY_DEPTH)-1:0] hist_wr_idx,
	input wire [oflow_iou_pkg::BBOX_LEN-1:0] hist_wr_box,
	input wire hist_clear,
	input wire det_start,
	input wire [oflow_iou_pkg::BBOX_LEN-1:0] det_box,
	input wire [oflow_iou_pkg::COST_LEN-1:0] cost_threshold,
	output logic busy,
	output logic match_done,
	output logic match_found,
	output logic [$clog2(HISTORY_DEPTH)-1:0] match_idx,
	output logic [oflow_iou_pkg::COST_LEN-1:0] match_cost
);

	// bank read port
	logic [$clog2(HISTORY_DEPTH)-1:0] rd_idx;
	logic [oflow_iou_pkg::BBOX_LEN-1:0] rd_box;
	logic rd_valid;

	// IoU handshake
	logic iou_start;
	logic valid_iou;
	logic [oflow_iou_pkg::COST_LEN-1:0] iou_cost;

	oflow_history_bank #(
		.HISTORY_DEPTH(HISTORY_DEPTH)
	) bank0 (
		.clk(clk),
		.reset_N(reset_N),
		.wr(hist_wr),
		.wr_idx(hist_wr_idx),
		.wr_box(hist_wr_box),
		.clear(hist_clear),
		.rd_idx(rd_idx),
		.rd_box(rd_box),
		.rd_valid(rd_valid)
	);

	oflow_best_match #(
		.HISTORY_DEPTH(HISTORY_DEPTH)
	) scan0 (
		.clk(clk),
		.reset_N(reset_N),
		.det_start(det_start),
		.cost_threshold(cost_threshold),
		.rd_idx(rd_idx),
		.rd_valid(rd_valid),
		.iou_start(iou_start),
		.valid_iou(valid_iou),
		.iou_cost(iou_cost),
		.busy(busy),
		.match_done(match_done),
		.match_found(match_found),
		.match_idx(match_idx),
		.match_cost(match_cost)
	);

	// history box captured on iou_start, same cycle as the read
	oflow_calc_iou iou0 (
		.clk(clk),
		.reset_N(reset_N),
		.start(iou_start),
		.bbox_frame_k(det_box),
		.bbox_frame_history(rd_box),
		.valid_iou(valid_iou),
		.iou_cost(iou_cost)
	);

endmodule

`default_nettype wire

/* rtl/oflow_iou_pkg.sv */
/* boxes are packed {x_tl, y_tl, x_br, y_br}, unsigned pixels, tl <= br assumed
   cost is 1 - IoU as an unsigned fraction with COST_FRAC bits */
`default_nettype none

package oflow_iou_pkg;

	// --------------------------------------------------
	// box layout
	// --------------------------------------------------
	// frames up to 1024 pixels per side
	localparam int COORD_LEN = 10;
	localparam int BBOX_LEN = 4 * COORD_LEN;

	// field msb positions, x_tl at the top
	localparam int X_TL_MSB = BBOX_LEN - 1;
	localparam int Y_TL_MSB = X_TL_MSB - COORD_LEN;
	localparam int X_BR_MSB = Y_TL_MSB - COORD_LEN;
	localparam int Y_BR_MSB = X_BR_MSB - COORD_LEN;

	// --------------------------------------------------
	// area and cost widths
	// --------------------------------------------------
	// product of two coordinate spans
	localparam int AREA_LEN = 2 * COORD_LEN;
	// sum of two areas, one carry bit
	localparam int UNION_LEN = AREA_LEN + 1;
	localparam int COST_FRAC = 22;
	localparam int COST_LEN = COST_FRAC;
	// intersection shifted up by the fraction bits
	localparam int DIV_NUM_LEN = AREA_LEN + COST_FRAC;

	// --------------------------------------------------
	// state encodings
	// --------------------------------------------------
	typedef enum logic [1:0] {
		calc_idle,
		calc_coord,
		calc_area,
		calc_divide
	} calc_state_t;

	typedef enum logic [1:0] {
		match_idle,
		match_fetch,
		match_wait_iou,
		match_report
	} match_state_t;

endpackage

`default_nettype wire

/* rtl/oflow_seq_divider.sv */
/* restoring divider, NUM_LEN >= 2, done exactly NUM_LEN cycles after start
   quotient and div_by_zero hold until the next start; start restarts at once */
`timescale 1ns/10ps
`default_nettype none

module oflow_seq_divider #(
	parameter int NUM_LEN = 42,
	parameter int DEN_LEN = 21
) (
	input wire clk,
	input wire reset_N,
	input wire start,
	input wire [NUM_LEN-1:0] dividend,
	input wire [DEN_LEN-1:0] divisor,
	output logic done,
	output logic div_by_zero,
	output logic [NUM_LEN-1:0] quotient
);

	localparam int CNT_LEN = $clog2(NUM_LEN + 1);

	logic running;
	logic [CNT_LEN-1:0] cnt;
	logic [DEN_LEN-1:0] rem;
	logic [DEN_LEN-1:0] den;

	// one step of the recurrence
	logic [DEN_LEN-1:0] rem_src;
	logic [NUM_LEN-1:0] quo_src;
	logic [DEN_LEN-1:0] den_src;
	logic [DEN_LEN:0] shifted;
	logic [DEN_LEN+1:0] trial;
	logic [DEN_LEN-1:0] rem_next;
	logic [NUM_LEN-1:0] quo_next;

	// --------------------------------------------------
	// shift and conditional subtract
	// --------------------------------------------------
	always_comb begin
		// first step runs straight off the inputs
		rem_src = start ? '0 : rem;
		quo_src = start ? dividend : quotient;
		den_src = start ? divisor : den;
		shifted = {rem_src, quo_src[NUM_LEN-1]};
		// extra top bit acts as the borrow
		trial = {1'b0, shifted} - {2'b00, den_src};
		if (trial[DEN_LEN+1]) begin
			// restore, quotient bit 0
			rem_next = shifted[DEN_LEN-1:0];
			quo_next = {quo_src[NUM_LEN-2:0], 1'b0};
		end else begin
			rem_next = trial[DEN_LEN-1:0];
			quo_next = {quo_src[NUM_LEN-2:0], 1'b1};
		end
	end

	// dividend bits shift out of quotient as result bits shift in
	always_ff @(posedge clk) begin
		if (start || running) begin
			rem <= rem_next;
			quotient <= quo_next;
		end
		if (start) begin
			den <= divisor;
		end
	end

	// --------------------------------------------------
	// bit counter and done pulse
	// --------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			running <= 1'b0;
			cnt <= '0;
			done <= 1'b0;
			div_by_zero <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				running <= 1'b1;
				cnt <= CNT_LEN'(NUM_LEN - 1);
				div_by_zero <= (divisor == '0);
			end else if (running) begin
				cnt <= cnt - 1'b1;
				// last bit lands this cycle
				if (cnt == CNT_LEN'(1)) begin
					running <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* sim/oflow_iou_match_tb.sv */
/* directed tests against a cost model; stops at the first mismatch
   inputs change on the falling edge, outputs are sampled there too */
`timescale 1ns/10ps
`default_nettype none

module oflow_iou_match_tb;

	localparam int HISTORY_DEPTH = 8;
	localparam int IDX_LEN = $clog2(HISTORY_DEPTH);
	localparam int BL = oflow_iou_pkg::BBOX_LEN;
	localparam int CL = oflow_iou_pkg::COORD_LEN;
	localparam int CST = oflow_iou_pkg::COST_LEN;
	localparam logic [CST-1:0] ALL_ONES = '1;
	// about 30 scans, each at worst every slot valid
	localparam int SCANS = 32;
	localparam int TIMEOUT_CYCLES =
		SCANS * HISTORY_DEPTH * (oflow_iou_pkg::DIV_NUM_LEN + 5) + 2000;

	logic clk;
	logic reset_N;
	logic hist_wr;
	logic [IDX_LEN-1:0] hist_wr_idx;
	logic [BL-1:0] hist_wr_box;
	logic hist_clear;
	logic det_start;
	logic [BL-1:0] det_box;
	logic [CST-1:0] cost_threshold;
	logic busy;
	logic match_done;
	logic match_found;
	logic [IDX_LEN-1:0] match_idx;
	logic [CST-1:0] match_cost;

	// bank contents as the testbench wrote them
	logic [BL-1:0] hist_box [HISTORY_DEPTH];
	logic hist_valid [HISTORY_DEPTH];
	logic [31:0] lfsr = 32'h769b;
	int cycles = 0;

	oflow_iou_match #(
		.HISTORY_DEPTH(HISTORY_DEPTH)
	) dut0 (
		.clk(clk),
		.reset_N(reset_N),
		.hist_wr(hist_wr),
		.hist_wr_idx(hist_wr_idx),
		.hist_wr_box(hist_wr_box),
		.hist_clear(hist_clear),
		.det_start(det_start),
		.det_box(det_box),
		.cost_threshold(cost_threshold),
		.busy(busy),
		.match_done(match_done),
		.match_found(match_found),
		.match_idx(match_idx),
		.match_cost(match_cost)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// --------------------------------------------------
	// failure handling and timeout
	// --------------------------------------------------
	task automatic abort_run();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
			abort_run();
		end
	endtask

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("timeout: the run went past %0d cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	// --------------------------------------------------
	// random numbers and boxes
	// --------------------------------------------------
	// galois form, taps 32 30 26 25
	function automatic logic lfsr_step();
		logic out;
		out = lfsr[0];
		lfsr = lfsr >> 1;
		if (out) begin
			lfsr = lfsr ^ 32'hA300_0000;
		end
		return out;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_step()};
		end
		return r;
	endfunction

	function automatic logic [BL-1:0] make_box(input int xtl, input int ytl,
			input int xbr, input int ybr);
		return {CL'(xtl), CL'(ytl), CL'(xbr), CL'(ybr)};
	endfunction

	// small coordinate range so boxes overlap often
	function automatic logic [BL-1:0] random_box();
		int a;
		int b;
		int c;
		int d;
		a = rand_bits(7);
		b = rand_bits(7);
		c = rand_bits(7);
		d = rand_bits(7);
		return make_box((a < b) ? a : b, (c < d) ? c : d, (a < b) ? b : a, (c < d) ? d : c);
	endfunction

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	function automatic longint field(input logic [BL-1:0] box, input int msb);
		return longint'(box[msb -: CL]);
	endfunction

	function automatic longint area_of(input logic [BL-1:0] box);
		return (field(box, oflow_iou_pkg::X_BR_MSB) - field(box, oflow_iou_pkg::X_TL_MSB)) *
			(field(box, oflow_iou_pkg::Y_BR_MSB) - field(box, oflow_iou_pkg::Y_TL_MSB));
	endfunction

	function automatic logic [CST-1:0] expected_cost(input logic [BL-1:0] a,
			input logic [BL-1:0] b);
		longint ix0;
		longint iy0;
		longint ix1;
		longint iy1;
		longint inter;
		longint uni;
		longint q;
		ix0 = field(a, oflow_iou_pkg::X_TL_MSB);
		if (field(b, oflow_iou_pkg::X_TL_MSB) > ix0) ix0 = field(b, oflow_iou_pkg::X_TL_MSB);
		iy0 = field(a, oflow_iou_pkg::Y_TL_MSB);
		if (field(b, oflow_iou_pkg::Y_TL_MSB) > iy0) iy0 = field(b, oflow_iou_pkg::Y_TL_MSB);
		ix1 = field(a, oflow_iou_pkg::X_BR_MSB);
		if (field(b, oflow_iou_pkg::X_BR_MSB) < ix1) ix1 = field(b, oflow_iou_pkg::X_BR_MSB);
		iy1 = field(a, oflow_iou_pkg::Y_BR_MSB);
		if (field(b, oflow_iou_pkg::Y_BR_MSB) < iy1) iy1 = field(b, oflow_iou_pkg::Y_BR_MSB);
		// negative overlap on either axis
		inter = ((ix1 < ix0) || (iy1 < iy0)) ? 0 : (ix1 - ix0) * (iy1 - iy0);
		uni = area_of(a) + area_of(b) - inter;
		if (uni == 0) begin
			return ALL_ONES;
		end
		q = (inter << oflow_iou_pkg::COST_FRAC) / uni;
		if (q >= (longint'(1) << oflow_iou_pkg::COST_FRAC)) begin
			return '0;
		end
		return CST'((longint'(1) << oflow_iou_pkg::COST_FRAC) - 1 - q);
	endfunction

	// lowest cost over valid slots, first slot wins a tie
	task automatic model_scan(input logic [BL-1:0] det, input logic [CST-1:0] thr,
			output logic [IDX_LEN-1:0] idx, output logic [CST-1:0] cost, output logic found);
		logic any;
		logic [CST-1:0] c;
		any = 1'b0;
		idx = '0;
		cost = ALL_ONES;
		for (int i = 0; i < HISTORY_DEPTH; i++) begin
			if (hist_valid[i]) begin
				c = expected_cost(det, hist_box[i]);
				if (!any || (c < cost)) begin
					cost = c;
					idx = IDX_LEN'(i);
				end
				any = 1'b1;
			end
		end
		found = any && (cost <= thr);
	endtask

	// --------------------------------------------------
	// bus actions, entered on a falling edge
	// --------------------------------------------------
	task automatic write_slot(input int idx, input logic [BL-1:0] box);
		hist_wr = 1'b1;
		hist_wr_idx = IDX_LEN'(idx);
		hist_wr_box = box;
		@(negedge clk);
		hist_wr = 1'b0;
		hist_box[idx] = box;
		hist_valid[idx] = 1'b1;
	endtask

	task automatic clear_history();
		hist_clear = 1'b1;
		@(negedge clk);
		hist_clear = 1'b0;
		for (int i = 0; i < HISTORY_DEPTH; i++) begin
			hist_valid[i] = 1'b0;
		end
	endtask

	task automatic run_scan(input logic [BL-1:0] det, input logic [CST-1:0] thr);
		det_box = det;
		cost_threshold = thr;
		det_start = 1'b1;
		@(negedge clk);
		det_start = 1'b0;
		while (match_done !== 1'b1) begin
			@(negedge clk);
		end
	endtask

	task automatic check_scan(input logic [BL-1:0] det, input logic [CST-1:0] thr);
		logic [IDX_LEN-1:0] idx;
		logic [CST-1:0] cost;
		logic found;
		run_scan(det, thr);
		model_scan(det, thr, idx, cost, found);
		check_value("match_idx", match_idx, idx);
		check_value("match_cost", match_cost, cost);
		check_value("match_found", match_found, found);
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------
	task automatic identical_and_disjoint();
		clear_history();
		write_slot(3, make_box(100, 50, 180, 120));
		check_scan(make_box(100, 50, 180, 120), '0);
		check_value("match_idx", match_idx, 3);
		check_value("match_cost", match_cost, 0);
		check_value("match_found", match_found, 1);
		clear_history();
		write_slot(1, make_box(300, 300, 350, 360));
		check_scan(make_box(100, 50, 180, 120), '0);
		check_value("match_cost", match_cost, ALL_ONES);
		check_value("match_found", match_found, 0);
	endtask

	task automatic partial_overlap_and_tie();
		clear_history();
		write_slot(0, make_box(10, 10, 60, 60));
		write_slot(1, make_box(20, 15, 70, 55));
		write_slot(4, make_box(30, 30, 90, 90));
		write_slot(6, make_box(0, 0, 40, 40));
		check_scan(make_box(18, 12, 66, 58), CST'(22'h200000));
		// same box twice, slot 2 must win
		clear_history();
		write_slot(0, make_box(500, 500, 520, 520));
		write_slot(2, make_box(40, 40, 80, 90));
		write_slot(5, make_box(40, 40, 80, 90));
		check_scan(make_box(50, 45, 85, 95), ALL_ONES);
		check_value("match_idx", match_idx, 2);
	endtask

	task automatic zero_area_boxes();
		clear_history();
		write_slot(0, make_box(10, 10, 10, 40));
		write_slot(4, make_box(0, 20, 50, 20));
		check_scan(make_box(10, 10, 10, 40), CST'(22'h3FFFFE));
		check_value("match_cost", match_cost, ALL_ONES);
		check_value("match_found", match_found, 0);
	endtask

	task automatic cleared_and_sparse_bank();
		for (int i = 0; i < HISTORY_DEPTH; i++) begin
			write_slot(i, make_box(i, i, i + 30, i + 30));
		end
		clear_history();
		check_scan(make_box(5, 5, 35, 35), ALL_ONES);
		check_value("match_found", match_found, 0);
		check_value("match_idx", match_idx, 0);
		check_value("match_cost", match_cost, ALL_ONES);
		// gaps at 0, 2, 4, 5, 7
		write_slot(1, make_box(0, 0, 30, 30));
		write_slot(3, make_box(6, 4, 36, 34));
		write_slot(6, make_box(10, 10, 40, 40));
		check_scan(make_box(5, 5, 35, 35), ALL_ONES);
	endtask

	task automatic threshold_edge_and_busy();
		logic [IDX_LEN-1:0] idx;
		logic [CST-1:0] best;
		logic found;
		clear_history();
		write_slot(2, make_box(100, 100, 160, 150));
		write_slot(7, make_box(90, 110, 150, 170));
		model_scan(make_box(95, 105, 155, 160), '0, idx, best, found);
		check_scan(make_box(95, 105, 155, 160), best);
		check_value("match_found", match_found, 1);
		check_scan(make_box(95, 105, 155, 160), best - 1'b1);
		check_value("match_found", match_found, 0);
		// second start while busy must be dropped
		cost_threshold = best;
		det_start = 1'b1;
		@(negedge clk);
		det_start = 1'b0;
		repeat (3) @(negedge clk);
		check_value("busy", busy, 1);
		det_start = 1'b1;
		@(negedge clk);
		det_start = 1'b0;
		while (match_done !== 1'b1) begin
			@(negedge clk);
		end
		check_value("match_found", match_found, 1);
		repeat (2 * (oflow_iou_pkg::DIV_NUM_LEN + 5)) begin
			@(negedge clk);
			check_value("match_done", match_done, 0);
			check_value("busy", busy, 0);
		end
	endtask

	task automatic random_boxes();
		logic [BL-1:0] det;
		logic [CST-1:0] thr;
		repeat (20) begin
			for (int i = 0; i < HISTORY_DEPTH; i++) begin
				write_slot(i, random_box());
			end
			det = random_box();
			thr = CST'(rand_bits(CST));
			check_scan(det, thr);
		end
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		reset_N = 1'b0;
		hist_wr = 1'b0;
		hist_wr_idx = '0;
		hist_wr_box = '0;
		hist_clear = 1'b0;
		det_start = 1'b0;
		det_box = '0;
		cost_threshold = '0;
		for (int i = 0; i < HISTORY_DEPTH; i++) begin
			hist_box[i] = '0;
			hist_valid[i] = 1'b0;
		end
		repeat (10) @(negedge clk);
		reset_N = 1'b1;
		@(negedge clk);
		check_value("busy", busy, 0);
		check_value("match_done", match_done, 0);
		check_value("match_found", match_found, 0);

		identical_and_disjoint();
		partial_overlap_and_tie();
		zero_area_boxes();
		cleared_and_sparse_bank();
		threshold_edge_and_busy();
		random_boxes();

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire
